// ==== include/hs32_macros.svh ====
// HS32 instruction field macros
`ifndef HS32_MACROS_SVH
`define HS32_MACROS_SVH

// Instruction word
`define HS32_INSTR_W    32

// Opcode byte
`define HS32_OPC_MSB    31
`define HS32_OPC_LSB    24

// Register index fields
`define HS32_RD_LSB     20
`define HS32_RM_LSB     16
`define HS32_RN_LSB     12
`define HS32_REG_W      4

// Shift amount and direction
`define HS32_SHIFT_LSB  7
`define HS32_SHIFT_W    5
`define HS32_DIR_LSB    5
`define HS32_DIR_W      2

// Immediate sits in the low bits
`define HS32_IMM_W      16

// Interrupt fabric
`define HS32_INT_LINES  24

// Upper opcode nibble of every conditional branch
`define HS32_BR_NIBBLE  4'h5

`endif

// ==== source/hs32_pkg.sv ====
// HS32 decode types
`include "hs32_macros.svh"

package hs32_pkg;

    // Kept opcodes, branch carries its condition in the low nibble
    typedef enum logic [7:0] {
        OPC_LDR  = 8'h10,
        OPC_LDRI = 8'h11,
        OPC_STR  = 8'h20,
        OPC_STRI = 8'h21,
        OPC_MOVI = 8'h30,
        OPC_MOVN = 8'h31,
        OPC_ADD  = 8'h40,
        OPC_ADDI = 8'h41,
        OPC_SUB  = 8'h42,
        OPC_SUBI = 8'h43,
        OPC_AND  = 8'h44,
        OPC_ANDI = 8'h45,
        OPC_OR   = 8'h46,
        OPC_ORI  = 8'h47,
        OPC_XOR  = 8'h48,
        OPC_XORI = 8'h49,
        OPC_CMP  = 8'h4A,
        OPC_CMPI = 8'h4B,
        OPC_B    = {`HS32_BR_NIBBLE, 4'h0}, // Branch always
        OPC_INT  = 8'h60
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_MOV = 4'h5
    } alu_op_e;

    // Second operand source for execute
    typedef enum logic [1:0] {
        SRC_IMM    = 2'd0, // Immediate alone
        SRC_RM_IMM = 2'd1, // Rm and immediate
        SRC_RM_SHN = 2'd2, // Rm and shifted Rn
        SRC_PC_IMM = 2'd3  // PC and immediate
    } src_e;

    typedef enum logic [1:0] {
        FAULT_NONE    = 2'd0,
        FAULT_SWI     = 2'd1,
        FAULT_ILLEGAL = 2'd2
    } fault_e;

    // Datapath flags
    typedef struct packed {
        logic                   reg_wr;    // Write back Rd
        logic                   mem_rd;    // Load
        logic                   mem_wr;    // Store
        src_e                   src;
        logic [3:0]             cond;      // Branch condition, 0 for others
        logic [`HS32_DIR_W-1:0] shift_dir;
    } ctl_t;

    // Full control word for execute
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [`HS32_SHIFT_W-1:0] shift;
        logic [`HS32_IMM_W-1:0]   imm;
        logic [`HS32_REG_W-1:0]   rd;
        logic [`HS32_REG_W-1:0]   rm;
        logic [`HS32_REG_W-1:0]   rn;
        ctl_t                     ctl;
    } ctl_word_t;

    // Table result handed to the stage
    typedef struct packed {
        ctl_word_t word;
        fault_e    fault;
    } decoded_t;

endpackage

// ==== source/hs32_decode_table.sv ====
// HS32 opcode decode table
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_decode_table (
    input  logic [`HS32_INSTR_W-1:0] instr,
    output hs32_pkg::decoded_t       decoded
);

    logic [`HS32_OPC_MSB-`HS32_OPC_LSB:0] opc;
    logic [`HS32_IMM_W-1:0]               imm_f;
    logic [`HS32_SHIFT_W-1:0]             shift_f;
    logic [3:0]                           cond_f;
    hs32_pkg::ctl_word_t                  word;
    hs32_pkg::fault_e                     fault;

    // ALU operation by opcode, branches and memory ops add
    function automatic hs32_pkg::alu_op_e alu_of(
        input logic [`HS32_OPC_MSB-`HS32_OPC_LSB:0] op
    );
        case (op)
            hs32_pkg::OPC_SUB, hs32_pkg::OPC_SUBI,
            hs32_pkg::OPC_CMP, hs32_pkg::OPC_CMPI: alu_of = hs32_pkg::ALU_SUB;
            hs32_pkg::OPC_AND, hs32_pkg::OPC_ANDI: alu_of = hs32_pkg::ALU_AND;
            hs32_pkg::OPC_OR,  hs32_pkg::OPC_ORI:  alu_of = hs32_pkg::ALU_OR;
            hs32_pkg::OPC_XOR, hs32_pkg::OPC_XORI: alu_of = hs32_pkg::ALU_XOR;
            hs32_pkg::OPC_MOVI, hs32_pkg::OPC_MOVN: alu_of = hs32_pkg::ALU_MOV;
            default:                               alu_of = hs32_pkg::ALU_ADD;
        endcase
    endfunction

    assign opc     = instr[`HS32_OPC_MSB:`HS32_OPC_LSB];
    assign imm_f   = instr[`HS32_IMM_W-1:0];
    assign shift_f = instr[`HS32_SHIFT_LSB +: `HS32_SHIFT_W];
    assign cond_f  = opc[3:0];

    always_comb begin
        word               = '0;
        word.alu_op        = alu_of(opc);
        word.rd            = instr[`HS32_RD_LSB +: `HS32_REG_W];
        word.rm            = instr[`HS32_RM_LSB +: `HS32_REG_W];
        word.rn            = instr[`HS32_RN_LSB +: `HS32_REG_W];
        word.ctl.shift_dir = instr[`HS32_DIR_LSB +: `HS32_DIR_W];
        fault              = hs32_pkg::FAULT_NONE;

        if (opc[7:4] == `HS32_BR_NIBBLE) begin
            word.imm      = imm_f;                                  // PC offset
            word.ctl.src  = hs32_pkg::SRC_PC_IMM;
            word.ctl.cond = (cond_f == 4'h0) ? 4'hF : cond_f;      // Zero means always
        end else begin
            case (opc)
                hs32_pkg::OPC_LDR, hs32_pkg::OPC_LDRI: begin
                    word.ctl.reg_wr = 1'b1;
                    word.ctl.mem_rd = 1'b1;
                    word.ctl.src    = hs32_pkg::SRC_RM_IMM;
                    if (opc == hs32_pkg::OPC_LDRI) begin
                        word.imm = imm_f;                           // Plain LDR uses offset 0
                    end
                end
                hs32_pkg::OPC_STR, hs32_pkg::OPC_STRI: begin
                    word.ctl.mem_wr = 1'b1;                         // Rd is the store data
                    word.ctl.src    = hs32_pkg::SRC_RM_IMM;
                    if (opc == hs32_pkg::OPC_STRI) begin
                        word.imm = imm_f;
                    end
                end
                hs32_pkg::OPC_MOVI: begin
                    word.ctl.reg_wr = 1'b1;
                    word.ctl.src    = hs32_pkg::SRC_IMM;
                    word.imm        = imm_f;
                end
                hs32_pkg::OPC_MOVN,
                hs32_pkg::OPC_ADD, hs32_pkg::OPC_SUB,
                hs32_pkg::OPC_AND, hs32_pkg::OPC_OR,
                hs32_pkg::OPC_XOR, hs32_pkg::OPC_CMP: begin
                    word.ctl.reg_wr = (opc != hs32_pkg::OPC_CMP);  // Compare only sets flags
                    word.ctl.src    = hs32_pkg::SRC_RM_SHN;
                    word.shift      = shift_f;
                end
                hs32_pkg::OPC_ADDI, hs32_pkg::OPC_SUBI,
                hs32_pkg::OPC_ANDI, hs32_pkg::OPC_ORI,
                hs32_pkg::OPC_XORI, hs32_pkg::OPC_CMPI: begin
                    word.ctl.reg_wr = (opc != hs32_pkg::OPC_CMPI);
                    word.ctl.src    = hs32_pkg::SRC_RM_IMM;
                    word.imm        = imm_f;
                end
                hs32_pkg::OPC_INT: begin
                    fault    = hs32_pkg::FAULT_SWI;
                    word.imm = imm_f;                               // Interrupt vector
                end
                default: begin
                    fault = hs32_pkg::FAULT_ILLEGAL;                // Unknown or dropped opcode
                end
            endcase
        end
    end

    assign decoded.word  = word;
    assign decoded.fault = fault;

endmodule

// ==== source/hs32_decode_stage.sv ====
// HS32 decode register stage
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  hs32_pkg::decoded_t     decoded,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    output hs32_pkg::ctl_word_t    ctl_out,
    output logic                   exe_valid,
    input  logic                   exe_ready,
    input  logic                   stall,
    output logic                   trap_req,
    output hs32_pkg::fault_e       trap_kind,
    output logic [`HS32_IMM_W-1:0] trap_vec
);

    logic                live;   // Set once out of reset
    logic                full;
    logic                good;
    logic                accept;
    hs32_pkg::ctl_word_t ctl_q;

    assign good        = (decoded.fault == hs32_pkg::FAULT_NONE);
    assign instr_ready = live && (!full || exe_ready) && !stall; // Empty or draining
    assign accept      = instr_valid && instr_ready;
    assign exe_valid   = full;
    assign ctl_out     = ctl_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            live     <= 1'b0;
            full     <= 1'b0;
            trap_req <= 1'b0;
        end else begin
            live <= 1'b1;
            if (accept && good) begin
                full <= 1'b1;                   // Refill, possibly while draining
            end else if (exe_ready) begin
                full <= 1'b0;
            end
            trap_req <= accept && !good;        // Faults never reach execute
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept && good) begin
            ctl_q <= decoded.word;
        end
        if (accept && !good) begin
            trap_kind <= decoded.fault;
            trap_vec  <= decoded.word.imm;
        end
    end

endmodule

// ==== source/hs32_trap_unit.sv ====
// HS32 interrupt trap unit
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_trap_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       trap_req,
    input  hs32_pkg::fault_e           trap_kind,
    input  logic [`HS32_IMM_W-1:0]     trap_vec,
    input  logic                       exe_ready,
    output logic                       stall,
    output logic [`HS32_INT_LINES-1:0] int_line
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        RAISE
    } state_e;

    state_e                      state;
    hs32_pkg::fault_e            kind_q;
    logic [`HS32_IMM_W-1:0]      vec_q;
    logic [`HS32_INT_LINES-1:0]  line_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (trap_req) state <= WAIT;
                WAIT:    if (exe_ready) state <= RAISE;   // Execute side can take it
                RAISE:   state <= IDLE;                   // Single pulse then resume
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && trap_req) begin
            kind_q <= trap_kind;
            vec_q  <= trap_vec;
        end
    end

    // One-hot line select, vectors past the last line raise nothing
    always_comb begin
        line_sel    = '0;
        line_sel[0] = (kind_q == hs32_pkg::FAULT_ILLEGAL) || (vec_q == '0);
        for (int i = 1; i < `HS32_INT_LINES; i++) begin
            line_sel[i] = (kind_q == hs32_pkg::FAULT_SWI) && (vec_q == i);
        end
    end

    assign stall    = trap_req || (state != IDLE);
    assign int_line = (state == RAISE) ? line_sel : '0;

endmodule

// ==== source/hs32_decode_top.sv ====
// HS32 decode stage top
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_decode_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`HS32_INSTR_W-1:0]   instr,
    input  logic                       instr_valid,
    output logic                       instr_ready,
    output hs32_pkg::ctl_word_t        ctl_out,
    output logic                       exe_valid,
    input  logic                       exe_ready,
    output logic [`HS32_INT_LINES-1:0] int_line
);

    hs32_pkg::decoded_t     decoded;
    hs32_pkg::fault_e       trap_kind;
    logic [`HS32_IMM_W-1:0] trap_vec;
    logic                   trap_req;
    logic                   stall;

    hs32_decode_table u_table (
        .instr   (instr),
        .decoded (decoded)
    );

    hs32_decode_stage u_stage (
        .clk         (clk),
        .reset       (reset),
        .decoded     (decoded),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .ctl_out     (ctl_out),
        .exe_valid   (exe_valid),
        .exe_ready   (exe_ready),
        .stall       (stall),
        .trap_req    (trap_req),
        .trap_kind   (trap_kind),
        .trap_vec    (trap_vec)
    );

    hs32_trap_unit u_trap (
        .clk       (clk),
        .reset     (reset),
        .trap_req  (trap_req),
        .trap_kind (trap_kind),
        .trap_vec  (trap_vec),
        .exe_ready (exe_ready),
        .stall     (stall),
        .int_line  (int_line)
    );

endmodule

// ==== verif/hs32_decode_asserts.sv ====
// HS32 decode protocol assertions
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_decode_asserts (
    input logic                       clk,
    input logic                       reset,
    input logic                       instr_ready,
    input logic                       exe_valid,
    input logic                       exe_ready,
    input hs32_pkg::ctl_word_t        ctl_out,
    input logic [`HS32_INT_LINES-1:0] int_line,
    input logic                       stall
);

    // Execute side keeps its word until taken
    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        exe_valid && !exe_ready |=> exe_valid && $stable(ctl_out))
        else $error("exe_valid or ctl_out changed while exe_ready was low");

    int_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(int_line))
        else $error("int_line has more than one line set");

    int_single_pulse: assert property (@(posedge clk) disable iff (reset)
        int_line != '0 |=> int_line == '0)
        else $error("int_line high on two cycles in a row");

    no_accept_in_stall: assert property (@(posedge clk) disable iff (reset)
        stall |-> !instr_ready)
        else $error("instr_ready high during stall");

endmodule

bind hs32_decode_top hs32_decode_asserts u_asserts (.*);

// ==== verif/hs32_decode_tb.sv ====
// HS32 decode stage testbench
`timescale 1ns/10ps
`include "hs32_macros.svh"

module hs32_decode_tb;

    localparam int          NUM_INSTR   = 500;
    localparam int          CYCLE_LIMIT = 4 * NUM_INSTR + 200;
    localparam logic [31:0] SEED        = 32'hd494_463d;

    logic                       clk;
    logic                       reset;
    logic [`HS32_INSTR_W-1:0]   instr;
    logic                       instr_valid;
    logic                       instr_ready;
    hs32_pkg::ctl_word_t        ctl_out;
    logic                       exe_valid;
    logic                       exe_ready;
    logic [`HS32_INT_LINES-1:0] int_line;

    hs32_pkg::ctl_word_t exp_q[$];     // Words owed to execute in order
    int                  int_q[$];     // Interrupt lines owed
    hs32_pkg::ctl_word_t held_word;
    hs32_pkg::ctl_word_t lat_word;
    logic                fire_in;      // Fetch transfer on the coming edge
    logic                hold_chk;
    logic                lat_chk;
    int                  issued;
    int                  good_accepts;
    int                  transfers;
    int                  cycles;
    int                  value_errs;
    int                  event_errs;

    logic [7:0] kept_ops [18] = '{
        hs32_pkg::OPC_LDR,  hs32_pkg::OPC_LDRI, hs32_pkg::OPC_STR,  hs32_pkg::OPC_STRI,
        hs32_pkg::OPC_MOVI, hs32_pkg::OPC_MOVN, hs32_pkg::OPC_ADD,  hs32_pkg::OPC_ADDI,
        hs32_pkg::OPC_SUB,  hs32_pkg::OPC_SUBI, hs32_pkg::OPC_AND,  hs32_pkg::OPC_ANDI,
        hs32_pkg::OPC_OR,   hs32_pkg::OPC_ORI,  hs32_pkg::OPC_XOR,  hs32_pkg::OPC_XORI,
        hs32_pkg::OPC_CMP,  hs32_pkg::OPC_CMPI
    };

    hs32_decode_top u_hs32_decode_top (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .ctl_out     (ctl_out),
        .exe_valid   (exe_valid),
        .exe_ready   (exe_ready),
        .int_line    (int_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_event(input string what);
        event_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    function automatic hs32_pkg::alu_op_e alu_for(input logic [7:0] opc);
        case (opc)
            hs32_pkg::OPC_ADD, hs32_pkg::OPC_ADDI: return hs32_pkg::ALU_ADD;
            hs32_pkg::OPC_AND, hs32_pkg::OPC_ANDI: return hs32_pkg::ALU_AND;
            hs32_pkg::OPC_OR,  hs32_pkg::OPC_ORI:  return hs32_pkg::ALU_OR;
            hs32_pkg::OPC_XOR, hs32_pkg::OPC_XORI: return hs32_pkg::ALU_XOR;
            default:                               return hs32_pkg::ALU_SUB; // SUB and compares
        endcase
    endfunction

    // Reference decode gives line -2 for a good word and -1 for a trap with no pulse
    task automatic model_decode(input logic [31:0] ins, output hs32_pkg::ctl_word_t w,
                                output int line);
        logic [7:0] opc;
        opc             = ins[`HS32_OPC_MSB:`HS32_OPC_LSB];
        w               = '0;
        line            = -2;
        w.rd            = ins[`HS32_RD_LSB +: `HS32_REG_W];
        w.rm            = ins[`HS32_RM_LSB +: `HS32_REG_W];
        w.rn            = ins[`HS32_RN_LSB +: `HS32_REG_W];
        w.ctl.shift_dir = ins[`HS32_DIR_LSB +: `HS32_DIR_W];
        if (opc[7:4] == `HS32_BR_NIBBLE) begin
            w.imm      = ins[15:0];
            w.ctl.src  = hs32_pkg::SRC_PC_IMM;
            w.ctl.cond = (opc[3:0] == 4'h0) ? 4'hF : opc[3:0];
        end else if (opc == hs32_pkg::OPC_INT) begin
            line = (ins[15:0] < `HS32_INT_LINES) ? int'(ins[15:0]) : -1;
        end else if (opc inside {hs32_pkg::OPC_LDR, hs32_pkg::OPC_LDRI,
                                 hs32_pkg::OPC_STR, hs32_pkg::OPC_STRI}) begin
            w.ctl.mem_rd = (opc inside {hs32_pkg::OPC_LDR, hs32_pkg::OPC_LDRI});
            w.ctl.mem_wr = !w.ctl.mem_rd;
            w.ctl.reg_wr = w.ctl.mem_rd;                    // Loads write back
            w.ctl.src    = hs32_pkg::SRC_RM_IMM;
            w.imm        = (opc inside {hs32_pkg::OPC_LDRI, hs32_pkg::OPC_STRI}) ? ins[15:0] : '0;
        end else if (opc inside {hs32_pkg::OPC_MOVI, hs32_pkg::OPC_MOVN}) begin
            w.alu_op     = hs32_pkg::ALU_MOV;
            w.ctl.reg_wr = 1'b1;
            w.ctl.src    = (opc == hs32_pkg::OPC_MOVI) ? hs32_pkg::SRC_IMM : hs32_pkg::SRC_RM_SHN;
            w.imm        = (opc == hs32_pkg::OPC_MOVI) ? ins[15:0] : '0;
            w.shift      = (opc == hs32_pkg::OPC_MOVI) ? '0 : ins[`HS32_SHIFT_LSB +: `HS32_SHIFT_W];
        end else if (opc inside {hs32_pkg::OPC_ADD, hs32_pkg::OPC_SUB, hs32_pkg::OPC_AND,
                                 hs32_pkg::OPC_OR, hs32_pkg::OPC_XOR, hs32_pkg::OPC_CMP}) begin
            w.alu_op     = alu_for(opc);
            w.ctl.reg_wr = (opc != hs32_pkg::OPC_CMP);
            w.ctl.src    = hs32_pkg::SRC_RM_SHN;
            w.shift      = ins[`HS32_SHIFT_LSB +: `HS32_SHIFT_W];
        end else if (opc inside {hs32_pkg::OPC_ADDI, hs32_pkg::OPC_SUBI, hs32_pkg::OPC_ANDI,
                                 hs32_pkg::OPC_ORI, hs32_pkg::OPC_XORI, hs32_pkg::OPC_CMPI}) begin
            w.alu_op     = alu_for(opc);
            w.ctl.reg_wr = (opc != hs32_pkg::OPC_CMPI);
            w.ctl.src    = hs32_pkg::SRC_RM_IMM;
            w.imm        = ins[15:0];
        end else begin
            line = 0;                                       // Unknown or dropped opcode
        end
    endtask

    function automatic logic [31:0] make_instr();
        logic [31:0] bits;
        int          pick;
        bits = $urandom();
        pick = $urandom_range(99);
        if (pick < 72) begin
            bits[31:24] = kept_ops[$urandom_range(17)];
        end else if (pick < 84) begin
            bits[31:24] = {`HS32_BR_NIBBLE, bits[27:24]};   // Any condition
        end else if (pick < 92) begin
            bits[31:24] = hs32_pkg::OPC_INT;
            if (pick < 90) begin
                bits[15:0] = 16'($urandom_range(31));       // Vectors around the line count
            end
        end
        return bits;                                        // Others keep a random opcode
    endfunction

    task automatic drive_cycle();
        if (fire_in || !instr_valid) begin
            if (issued < NUM_INSTR && $urandom_range(99) < 75) begin
                instr       <= make_instr();
                instr_valid <= 1'b1;
                issued++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
        exe_ready <= ($urandom_range(99) < 70);
    endtask

    // Scoreboard sampled mid-cycle
    always @(negedge clk) begin : monitor
        hs32_pkg::ctl_word_t w;
        int                  line;
        if (!reset) begin
            if (lat_chk) begin
                check_val("exe_valid", exe_valid, 1);
                check_val("ctl_out", ctl_out, lat_word);
            end
            if (hold_chk && (!exe_valid || ctl_out !== held_word)) begin
                report_event("execute output changed while exe_ready was low");
            end
            hold_chk  = exe_valid && !exe_ready;
            held_word = ctl_out;
            fire_in   = instr_valid && instr_ready;
            lat_chk   = 1'b0;
            if (fire_in) begin
                model_decode(instr, w, line);
                if (line == -2) begin
                    exp_q.push_back(w);
                    good_accepts++;
                    lat_chk  = 1'b1;
                    lat_word = w;
                end else if (line >= 0) begin
                    int_q.push_back(line);
                end
            end
            if (exe_valid && exe_ready) begin
                transfers++;
                if (exp_q.size() == 0) begin
                    report_event("control word sent to execute with none expected");
                end else begin
                    check_val("ctl_out", ctl_out, exp_q.pop_front());
                end
            end
            if (int_line != '0) begin
                if (int_q.size() == 0) begin
                    report_event("interrupt pulse with none expected");
                end else begin
                    check_val("int_line", int_line, 64'(1) << int_q.pop_front());
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d words and %0d interrupts missing",
                 cycles, exp_q.size(), int_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        exe_ready    = 1'b0;
        fire_in      = 1'b0;
        hold_chk     = 1'b0;
        lat_chk      = 1'b0;
        issued       = 0;
        good_accepts = 0;
        transfers    = 0;
        value_errs   = 0;
        event_errs   = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("instr_ready", instr_ready, 0);
        check_val("exe_valid", exe_valid, 0);
        check_val("int_line", int_line, 0);
        while (issued < NUM_INSTR || instr_valid) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);                                 // Let the new drive settle
        end
        while (exp_q.size() != 0 || int_q.size() != 0) begin
            @(posedge clk);
            drive_cycle();
        end
        repeat (20) begin                                   // Catch late stray pulses
            @(posedge clk);
            drive_cycle();
        end
        check_val("transfer count", transfers, good_accepts);
        $display("Errors: %0d value mismatches, %0d protocol errors over %0d transfers",
                 value_errs, event_errs, transfers);
        if (value_errs + event_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
source/hs32_pkg.sv
source/hs32_decode_table.sv
source/hs32_decode_stage.sv
source/hs32_trap_unit.sv
source/hs32_decode_top.sv
verif/hs32_decode_asserts.sv
verif/hs32_decode_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= hs32_decode_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= CHECKS FAILED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "^exit status 0$$" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
